// ==== Bender.yml ====
package:
  name: keccak

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/keccak_pkg.sv
      - source/padder_byte.sv
      - source/padder.sv
      - source/round_constant.sv
      - source/keccak_round.sv
      - source/f_permutation.sv
      - source/keccak.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/keccak_tb.sv

// ==== source/f_permutation.sv ====
/*
 * Absorbs rate blocks and runs Keccak-f[1600], one round per clock.
 * ack is combinational and high while a block waits and the core is idle.
 * A block takes 24 cycles after ack. last_block is sampled with ack.
 * digest_ready holds until reset.
 */
`include "keccak_defines.svh"

module f_permutation (
    input  logic                            clk,
    input  logic                            reset,
    input  keccak_pkg::block_t              block,
    input  logic                            block_ready,
    input  logic                            last_block,
    output logic                            ack,
    output logic [`KECCAK_DIGEST_WIDTH-1:0] digest,
    output logic                            digest_ready
);

    keccak_pkg::state_t       state;     // Permutation state
    keccak_pkg::state_t       round_out; // State after one round
    keccak_pkg::round_index_t round;     // Current round
    keccak_pkg::lane_t        rc;        // Iota constant for this round
    logic                     busy;      // Rounds in progress
    logic                     last_q;    // Block in flight is the final one

    assign ack    = block_ready & ~busy;
    assign digest = state[0:`KECCAK_DIGEST_WIDTH/64-1]; // Lanes 0 to 7

    round_constant rc0 (
        .round (round),
        .rc    (rc)
    );

    keccak_round kr0 (
        .state_in  (state),
        .rc        (rc),
        .state_out (round_out)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= '0; // Sponge starts from all zero
            round        <= '0;
            busy         <= 1'b0;
            last_q       <= 1'b0;
            digest_ready <= 1'b0;
        end
        else if (ack)
        begin
            state  <= state ^ {block, {`KECCAK_CAPACITY{1'b0}}}; // Absorb into rate
            round  <= '0;
            busy   <= 1'b1;
            last_q <= last_block;
        end
        else if (busy)
        begin
            state <= round_out;
            round <= round + 5'd1;
            if (round == 5'(`KECCAK_ROUNDS - 1))
            begin
                busy <= 1'b0; // Free for the next block
                if (last_q)
                    digest_ready <= 1'b1;
            end
        end
    end

endmodule

// ==== source/keccak.sv ====
/*
 * Keccak-512 top level, pre-SHA-3 padding, rate 576, capacity 1024.
 * Feed 64-bit words while buffer_full is low and hold each word until it
 * is taken. One message per reset. The digest is valid while
 * digest_ready is high, first byte in bits 511:504.
 */
`include "keccak_defines.svh"

module keccak (
    input  logic                            clk,
    input  logic                            reset,
    input  keccak_pkg::in_word_t            in,
    input  logic                            in_ready,
    output logic                            buffer_full,
    output logic [`KECCAK_DIGEST_WIDTH-1:0] digest,
    output logic                            digest_ready
);

    keccak_pkg::block_t block;       // Rate block from padder
    logic               block_ready; // Padder holds nine words
    logic               ack;         // Permutation took the block
    logic               done;        // Final block offered

    padder padder0 (
        .clk         (clk),
        .reset       (reset),
        .in          (in),
        .in_ready    (in_ready),
        .buffer_full (buffer_full),
        .block       (block),
        .block_ready (block_ready),
        .done        (done),
        .ack         (ack)
    );

    f_permutation perm0 (
        .clk          (clk),
        .reset        (reset),
        .block        (block),
        .block_ready  (block_ready),
        .last_block   (done),
        .ack          (ack),
        .digest       (digest),
        .digest_ready (digest_ready)
    );

endmodule

// ==== source/keccak_defines.svh ====
/*
 * Sizes for the Keccak-512 core in the original pre-SHA-3 form.
 * The permutation width is fixed at 1600 bits. Rate plus capacity must
 * equal the width, and the rate must be a whole number of input words.
 */
`ifndef KECCAK_DEFINES_SVH
`define KECCAK_DEFINES_SVH

// Permutation state width in bits
`define KECCAK_WIDTH 1600

// Hidden part of the state
`define KECCAK_CAPACITY 1024

// Bits absorbed per block
`define KECCAK_RATE 576

// One user word per clock
`define KECCAK_IN_WIDTH 64

// Rate divided by input width
`define KECCAK_WORDS_PER_BLOCK 9

// First bits of state taken as the hash
`define KECCAK_DIGEST_WIDTH 512

// Rounds of Keccak-f[1600]
`define KECCAK_ROUNDS 24

`endif

// ==== source/keccak_pkg.sv ====
/*
 * Types shared by the Keccak-512 core.
 * A state holds 25 lanes with lane (x,y) at index x+5y and lane 0 in the
 * top bits. Lanes keep message bytes in stream order, first byte on top.
 */
`include "keccak_defines.svh"

package keccak_pkg;

    // One 64-bit lane
    typedef logic [`KECCAK_WIDTH/25-1:0] lane_t;

    // Lane 0 sits in the most significant bits
    typedef lane_t [0:24] state_t;

    // One user word with its framing
    typedef struct packed {
        logic [`KECCAK_IN_WIDTH-1:0] data;     // First byte in bits 63:56
        logic                        is_last;  // Final word of the message
        logic [3:0]                  byte_num; // Valid bytes when is_last
    } in_word_t;

    // Rate part of one block, first word on top
    typedef logic [`KECCAK_RATE-1:0] block_t;

    // Round counter 0 to 23
    typedef logic [4:0] round_index_t;

endpackage

// ==== source/keccak_round.sv ====
/*
 * One combinational round of Keccak-f[1600].
 * Input and output lanes hold bytes in stream order, first byte on top.
 * They are byte-swapped into native lane order around the round logic.
 * rc must already be in native lane order.
 */
module keccak_round (
    input  keccak_pkg::state_t state_in,
    input  keccak_pkg::lane_t  rc,
    output keccak_pkg::state_t state_out
);

    // Rho rotation offsets indexed by x+5y
    localparam int RHO [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    keccak_pkg::lane_t a [25]; // Native lanes in
    keccak_pkg::lane_t b [25]; // After rho and pi
    keccak_pkg::lane_t e [25]; // After chi and iota
    keccak_pkg::lane_t c [5];  // Column parity
    keccak_pkg::lane_t d [5];  // Theta mix per column

    function automatic keccak_pkg::lane_t rotl(keccak_pkg::lane_t v, int n);
        return (v << n) | (v >> (64 - n)); // n of 0 gives v
    endfunction

    function automatic keccak_pkg::lane_t bswap(keccak_pkg::lane_t v);
        keccak_pkg::lane_t r;
        for (int k = 0; k < 8; k++)
        begin
            r[8*k +: 8] = v[56-8*k +: 8];
        end
        return r;
    endfunction

    always_comb
    begin
        for (int i = 0; i < 25; i++)
        begin
            a[i] = bswap(state_in[i]); // Stream order to native
        end

        // Theta
        for (int x = 0; x < 5; x++)
        begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++)
        begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
        end
        for (int i = 0; i < 25; i++)
        begin
            a[i] = a[i] ^ d[i%5];
        end

        // Rho and pi, lane (x,y) moves to (y, 2x+3y)
        for (int x = 0; x < 5; x++)
        begin
            for (int y = 0; y < 5; y++)
            begin
                b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y], RHO[x + 5*y]);
            end
        end

        // Chi along each row
        for (int x = 0; x < 5; x++)
        begin
            for (int y = 0; y < 5; y++)
            begin
                e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
            end
        end

        e[0] = e[0] ^ rc; // Iota

        for (int i = 0; i < 25; i++)
        begin
            state_out[i] = bswap(e[i]); // Back to stream order
        end
    end

endmodule

// ==== source/padder.sv ====
/*
 * Packs user words into rate blocks and applies Keccak multi-rate padding.
 * A word is taken on each edge with in_ready high and buffer_full low.
 * Only one message is handled per reset. done rises as the final block
 * fills and holds until reset.
 */
`include "keccak_defines.svh"

module padder (
    input  logic                 clk,
    input  logic                 reset,
    input  keccak_pkg::in_word_t in,
    input  logic                 in_ready,
    output logic                 buffer_full,
    output keccak_pkg::block_t   block,
    output logic                 block_ready,
    output logic                 done,
    input  logic                 ack
);

    localparam int WORDS = `KECCAK_WORDS_PER_BLOCK;

    logic [WORDS-1:0]  fill;      // One-hot fill, bit k set after k+1 words
    logic              ended;     // Last user word taken
    logic              padded;    // 0x01 pad byte already placed
    keccak_pkg::lane_t tail_word; // Final word with pad byte
    keccak_pkg::lane_t word;      // Word shifted in this cycle
    logic              update;    // Shift a word into the block
    logic              pad_now;   // This word carries the 0x01 byte
    logic              final_blk; // Current block is the final one

    assign buffer_full = fill[WORDS-1];
    assign block_ready = buffer_full;
    assign update      = (in_ready | ended) & ~buffer_full & ~done;

    padder_byte pb0 (
        .data     (in.data),
        .byte_num (in.byte_num),
        .padded   (tail_word)
    );

    always_comb
    begin
        if (ended)
        begin
            word    = padded ? '0 : {8'h01, {(`KECCAK_IN_WIDTH-8){1'b0}}}; // Generated
            pad_now = ~padded;
        end
        else if (in.is_last)
        begin
            word    = tail_word;
            pad_now = (in.byte_num < 4'd8); // Full last word defers the pad
        end
        else
        begin
            word    = in.data;
            pad_now = 1'b0;
        end
        final_blk = padded | pad_now;
        word[7]   = word[7] | (fill[WORDS-2] & final_blk); // 0x80 in last byte of ninth word
    end

    // Payload shift, first word ends up on top
    always_ff @(posedge clk)
    begin
        if (update)
        begin
            block <= {block[`KECCAK_RATE-`KECCAK_IN_WIDTH-1:0], word};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fill   <= '0;
            ended  <= 1'b0;
            padded <= 1'b0;
            done   <= 1'b0;
        end
        else
        begin
            if (ack)
                fill <= '0; // Permutation took the block
            else if (update)
                fill <= {fill[WORDS-2:0], 1'b1};
            if (update & ~ended & in.is_last)
                ended <= 1'b1;
            if (update & pad_now)
                padded <= 1'b1;
            if (update & fill[WORDS-2] & final_blk)
                done <= 1'b1; // Final block now full
        end
    end

endmodule

// ==== source/padder_byte.sv ====
/*
 * Pads the final message word.
 * Keeps the first byte_num bytes, puts 0x01 in the next byte and zeroes
 * the rest. byte_num of 8 or more returns the word unchanged, so the
 * caller must supply the 0x01 byte in a following word.
 */
`include "keccak_defines.svh"

module padder_byte (
    input  keccak_pkg::lane_t data,
    input  logic [3:0]        byte_num,
    output keccak_pkg::lane_t padded
);

    localparam int BYTES = `KECCAK_IN_WIDTH / 8; // Bytes per word

    always_comb
    begin
        padded = '0;
        for (int b = 0; b < BYTES; b++)
        begin
            // Byte b lives at bits 63-8b down to 56-8b
            if (b < int'(byte_num))
            begin
                padded[`KECCAK_IN_WIDTH-1-8*b -: 8] = data[`KECCAK_IN_WIDTH-1-8*b -: 8]; // Message
            end
            else if (b == int'(byte_num))
            begin
                padded[`KECCAK_IN_WIDTH-1-8*b -: 8] = 8'h01; // Start of pad
            end
        end
    end

endmodule

// ==== source/round_constant.sv ====
/*
 * Iota round constants of Keccak-f[1600].
 * Constants are in native lane bit order, bit z of the lane at index z.
 * Round indices above 23 give zero.
 */
module round_constant (
    input  keccak_pkg::round_index_t round,
    output keccak_pkg::lane_t        rc
);

    always_comb
    begin
        case (round)
            5'd0:    rc = 64'h0000_0000_0000_0001;
            5'd1:    rc = 64'h0000_0000_0000_8082;
            5'd2:    rc = 64'h8000_0000_0000_808A;
            5'd3:    rc = 64'h8000_0000_8000_8000;
            5'd4:    rc = 64'h0000_0000_0000_808B;
            5'd5:    rc = 64'h0000_0000_8000_0001;
            5'd6:    rc = 64'h8000_0000_8000_8081;
            5'd7:    rc = 64'h8000_0000_0000_8009;
            5'd8:    rc = 64'h0000_0000_0000_008A;
            5'd9:    rc = 64'h0000_0000_0000_0088;
            5'd10:   rc = 64'h0000_0000_8000_8009;
            5'd11:   rc = 64'h0000_0000_8000_000A;
            5'd12:   rc = 64'h0000_0000_8000_808B;
            5'd13:   rc = 64'h8000_0000_0000_008B;
            5'd14:   rc = 64'h8000_0000_0000_8089;
            5'd15:   rc = 64'h8000_0000_0000_8003;
            5'd16:   rc = 64'h8000_0000_0000_8002;
            5'd17:   rc = 64'h8000_0000_0000_0080;
            5'd18:   rc = 64'h0000_0000_0000_800A;
            5'd19:   rc = 64'h8000_0000_8000_000A;
            5'd20:   rc = 64'h8000_0000_8000_8081;
            5'd21:   rc = 64'h8000_0000_0000_8080;
            5'd22:   rc = 64'h0000_0000_8000_0001;
            5'd23:   rc = 64'h8000_0000_8000_8008;
            default: rc = '0; // Unused indices
        endcase
    end

endmodule

// ==== src.f ====
+incdir+source
source/keccak_pkg.sv
source/padder_byte.sv
source/padder.sv
source/round_constant.sv
source/keccak_round.sv
source/f_permutation.sv
source/keccak.sv
test/keccak_tb.sv

// ==== test/keccak_golden.hex ====
// Per message: word count, then one line per word with data, is_last, byte_num,
// then the 512-bit digest as two 256-bit halves. A count of 0 ends the list.
// Empty message
1
0000000000000000 1 0
0eab42de4c3ceb9235fc91acffe746b29c29a8c366b7c60e4e67c466f36a4304
c00fa9caf9d87976ba469bcbe06713b435f091ef2769fb160cdab33d3670680e
// CC
1
cc00000000000000 1 1
8630c13cbd066ea74bbe7fe468fec1dee10edc1254fb4c1b7c5fd69b646e4416
0b8ce01d05a0908ca790dfb080f4b513bc3b6225ece7a810371441a5ac666eb9
// 41FB
1
41fb000000000000 1 2
551da6236f8b96fce9f97f1190e901324f0b45e06dbbb5cdb8355d6ed1dc34b3
f0eae7dcb68622ff232fa3cece0d4616cdeb3931f93803662a28df1cd535b731
// 1F877C
1
1f877c0000000000 1 3
eb7f2a98e00af37d964f7d8c44c1fb6e114d8ee21a7b976ae736539efdc1e3fe
43becef5015171e6da30168cae99a82c53fa99042774ef982c01626a540f08c0
// C1ECFDFC
1
c1ecfdfc00000000 1 4
952d4c0a6f0ef5ce438c52e3edd345ea00f91cf5da8097c1168a16069e958fc0
5bad90a0c5fb4dd9ec28e84b226b94a847d6bb89235692ef4c9712f0c7030fae
// 21F134AC57
1
21f134ac57000000 1 5
2e76d93affd62b92fc4f29cb83efbe4ba21d88426aa7f075bfc20960ea258787
898172e17045af43ab1fe445532be0185fbea84d9be788b05f14dbf4856a5254
// C6F50BB74E29
1
c6f50bb74e290000 1 6
40fa8074e1e509b206448fbe757d9494b9b51e8d6e674a67f53c11ef92e96c3e
a08b95ebd4172b020010cd6cf29539a34d6bfa002a2042787aa8d879a0f5b54c
// 119713CC83EEEF
1
119713cc83eeef00 1 7
d1116786a3c1ea46a8f22d82abb4c5d06dc0691b2e747ac9726d0b290e6959f7
b23428519a656b237695e56403855ec4c98db0cf87f31b6ceabf2b9b8589b713
// 4A4F202484512526, full last word
1
4a4f202484512526 1 8
f326c7c126ddc277922760feef77c9bab6fb5d3430f652593703d7c5e30135cd
0b0575257509a624184330d6ab1f508a666391b5d4690426b4e05301891df897
// abc
1
6162630000000000 1 3
18587dc2ea106b9a1563e32b3312421ca164c7f1f07bc922a9c83d77cea3a1e5
d0c69910739025372dc14ac9642629379540c17e2a65b19d77aa511a9d00bb96
// The quick brown fox jumps over the lazy dog
6
5468652071756963 0 8
6b2062726f776e20 0 8
666f78206a756d70 0 8
73206f7665722074 0 8
6865206c617a7920 0 8
646f670000000000 1 3
d135bb84d0439dbac432247ee573a23ea7d3c9deb2a968eb31d47c4fb45f1ef4
422d6c531b5b9bd6f449ebcc449ea94d0a8f05f62130fda612da53c79659f609
// The quick brown fox jumps over the lazy dog.
6
5468652071756963 0 8
6b2062726f776e20 0 8
666f78206a756d70 0 8
73206f7665722074 0 8
6865206c617a7920 0 8
646f672e00000000 1 4
ab7192d2b11f51c7dd744e7b3441febf397ca07bf812cceae122ca4ded638788
9064f8db9230f173f6d1ab6e24b6e50f065b039f799f5592360a6558eb52d760
0

// ==== test/keccak_tb.sv ====
/*
 * Testbench for the Keccak-512 core.
 * Messages and expected digests come from test/keccak_golden.hex, read
 * relative to the project root. Every message runs after its own reset.
 * Idle gaps between words come from an LFSR with a fixed seed.
 */
`include "keccak_defines.svh"

module keccak_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int GOLDEN_DEPTH = 256;
    localparam int HOLD_CYCLES  = 6;  // Cycles the digest is watched after it shows up

    logic                            clk;
    logic                            reset;
    keccak_pkg::in_word_t            in;
    logic                            in_ready;
    logic                            buffer_full;
    logic [`KECCAK_DIGEST_WIDTH-1:0] digest;
    logic                            digest_ready;

    logic [255:0] golden [0:GOLDEN_DEPTH-1]; // Counts, words, digest halves
    logic [31:0]  lfsr;                      // Idle gap source
    longint       budget_cycles;             // Watchdog limit, 0 until known

    keccak dut0 (
        .clk          (clk),
        .reset        (reset),
        .in           (in),
        .in_ready     (in_ready),
        .buffer_full  (buffer_full),
        .digest       (digest),
        .digest_ready (digest_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic pick_gap(output int gap);
        gap = 0;
        for (int k = 0; k < 2; k++)
        begin
            lfsr = lfsr_step(lfsr); // One step per bit taken
            gap  = 2*gap + int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] expected);
        if (got !== expected)
        begin
            $display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset    = 1'b1;
        in_ready = 1'b0;
        in       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_value("buffer_full", buffer_full, 1'b0);   // Cleared by reset
        check_value("digest_ready", digest_ready, 1'b0);
    endtask

    // Starts and ends on a falling edge
    task automatic send_word(input keccak_pkg::in_word_t w);
        while (buffer_full)
        begin
            check_value("digest_ready", digest_ready, 1'b0);
            @(negedge clk); // Block waiting for the permutation
        end
        in       = w;
        in_ready = 1'b1;
        @(negedge clk); // Taken on the rising edge in between
        in_ready = 1'b0;
        check_value("digest_ready", digest_ready, 1'b0); // Too early for a digest
    endtask

    task automatic run_test(inout int ptr, input int test_num);
        int                   count;
        int                   gap;
        keccak_pkg::in_word_t w;
        logic [511:0]         expected;
        count = int'(golden[ptr]);
        apply_reset();
        for (int i = 0; i < count; i++)
        begin
            w.data     = golden[ptr + 1 + 3*i][63:0];
            w.is_last  = golden[ptr + 2 + 3*i][0];
            w.byte_num = golden[ptr + 3 + 3*i][3:0];
            send_word(w);
            if (i < count - 1)
            begin
                pick_gap(gap);
                repeat (gap) @(negedge clk); // 0 to 3 idle cycles
            end
        end
        expected = {golden[ptr + 1 + 3*count], golden[ptr + 2 + 3*count]};
        while (!digest_ready)
            @(negedge clk); // Watchdog covers a hang here
        check_value("digest", digest, expected);
        repeat (HOLD_CYCLES)
        begin
            @(negedge clk);
            check_value("digest_ready", digest_ready, 1'b1); // Sticky until reset
            check_value("digest", digest, expected);
        end
        $display("message %0d with %0d words matched", test_num, count);
        ptr = ptr + 3*count + 3;
    endtask

    initial
    begin
        int ptr;
        int count;
        int blocks;
        int tests;
        reset         = 1'b1;
        in_ready      = 1'b0;
        in            = '0;
        lfsr          = 32'h207e;
        budget_cycles = 0;
        $readmemh("test/keccak_golden.hex", golden);
        if ($isunknown(golden[0]) || golden[0] == 0)
        begin
            $display("The golden file is missing or holds no messages");
            $display("test failed");
            $fatal(1);
        end
        ptr   = 0;
        tests = 0;
        while (ptr < GOLDEN_DEPTH && !$isunknown(golden[ptr]) && golden[ptr] != 0)
        begin
            count  = int'(golden[ptr]);
            blocks = (count + ((golden[ptr + 3*count][3:0] == 4'd8) ? 1 : 0) + 8) / 9;
            budget_cycles = budget_cycles + blocks*40 + 60;
            ptr   = ptr + 3*count + 3;
            tests = tests + 1;
        end
        ptr = 0;
        for (int t = 0; t < tests; t++)
        begin
            run_test(ptr, t);
        end
        $display("test passed");
        $finish;
    end

    // Watchdog, limit derived from the message lengths
    initial
    begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("The digest never arrived within %0d clock cycles", budget_cycles);
        $display("test failed");
        $fatal(1);
    end

endmodule
